// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ls_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
src/ls_pkg.sv
src/ls_reg_file.sv
src/ls_unit.sv
src/ls_data_ram.sv
src/ls_top.sv
tests/ls_checker.sv
tests/ls_tb.sv

// File: src/ls_data_ram.sv
/* Word RAM with one cycle read latency and byte-masked writes
   Only the low word-address bits are decoded, so upper addresses alias */
`timescale 1ns/10ps

module ls_data_ram
(
    input  logic              clk,

    input  ls_pkg::dbus_req_t dbus,
    output ls_pkg::word_t     rdata
);

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    ls_pkg::word_t                     mem [2**ls_pkg::RAM_WORDS_LOG2];
    logic [ls_pkg::RAM_WORDS_LOG2-1:0] widx;

    assign widx = dbus.addr[ls_pkg::RAM_WORDS_LOG2+1:2];   // Byte address to word index

    initial
    begin
        for (int i = 0; i < 2**ls_pkg::RAM_WORDS_LOG2; i++)
        begin
            mem[i] = '0;
        end
    end

    //////////////////////////////////////////////////
    // Access port
    //////////////////////////////////////////////////

    // Read returns the word as it was before this cycle's write,
    // which gives an exchange its old value
    always_ff @(posedge clk)
    begin
        if (dbus.cs)
        begin
            rdata <= mem[widx];
            if (dbus.wr)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    if (dbus.mask[b])
                    begin
                        mem[widx][8*b +: 8] <= dbus.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: src/ls_pkg.sv
/* Widths, size codes and bus structs of the load/store slice
   Struct fields are listed MSB first, as they appear on the ports */
package ls_pkg;

    typedef logic [31:0] word_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [3:0]  byte_mask_t;
    typedef logic [1:0]  size_t;
    typedef logic [4:0]  offset_t;

    // Access size codes, SIZE_XCHG is a word access
    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;
    localparam size_t SIZE_XCHG = 2'd3;

    localparam int RCN_SELECT_BIT = 31;   // Set means the remote bus
    localparam int RAM_WORDS_LOG2 = 10;
    localparam int NUM_REGS       = 8;

    typedef struct packed {
        logic     store;
        logic     post_inc;
        size_t    size;
        offset_t  offset;
        reg_idx_t ptr;
        reg_idx_t data_reg;
    } ls_op_t;

    typedef struct packed {
        logic       cs;
        logic       wr;
        word_t      addr;
        byte_mask_t mask;
        word_t      wdata;
    } dbus_req_t;

    typedef struct packed {
        logic       cs;
        logic       xch;
        logic       wr;
        word_t      addr;
        reg_idx_t   wbreg;
        byte_mask_t mask;
        word_t      wdata;
    } rcn_req_t;

    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        word_t    data;
    } wb_t;

endpackage

// File: src/ls_reg_file.sv
/* Eight registers, one write per register per cycle
   Priority is load write back, then pointer update, then host */
`timescale 1ns/10ps

module ls_reg_file
(
    input  logic                                  clk,
    input  logic                                  rst,

    input  ls_pkg::wb_t                           host_wb,
    input  ls_pkg::wb_t                           wb_load,
    input  ls_pkg::wb_t                           wb_ptr,

    input  ls_pkg::reg_idx_t                      rd_idx,
    output ls_pkg::word_t                         rd_data,

    output ls_pkg::word_t [ls_pkg::NUM_REGS-1:0]  regs
);

    //////////////////////////////////////////////////
    // Write ports
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            regs <= '0;
        end
        else
        begin
            for (int i = 0; i < ls_pkg::NUM_REGS; i++)
            begin
                if (wb_load.en && (wb_load.idx == ls_pkg::reg_idx_t'(i)))
                begin
                    regs[i] <= wb_load.data;
                end
                else if (wb_ptr.en && (wb_ptr.idx == ls_pkg::reg_idx_t'(i)))
                begin
                    regs[i] <= wb_ptr.data;
                end
                else if (host_wb.en && (host_wb.idx == ls_pkg::reg_idx_t'(i)))
                begin
                    regs[i] <= host_wb.data;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////

    assign rd_data = regs[rd_idx];   // No bypass of same-cycle writes

endmodule

// File: src/ls_top.sv
/* Load/store slice with register file and local data RAM
   Remote requests leave through rcn_req and get no response */
`timescale 1ns/10ps

module ls_top
(
    input  logic              clk,
    input  logic              rst,

    input  ls_pkg::wb_t       host_wb,

    input  ls_pkg::reg_idx_t  rd_idx,
    output ls_pkg::word_t     rd_data,

    input  logic              dir_en,
    input  logic              dir_store,
    input  ls_pkg::reg_idx_t  dir_reg,
    input  ls_pkg::word_t     dir_addr,

    input  logic              op_en,
    input  ls_pkg::ls_op_t    op,

    output ls_pkg::rcn_req_t  rcn_req
);

    ls_pkg::word_t [ls_pkg::NUM_REGS-1:0] regs;
    ls_pkg::dbus_req_t                    dbus;
    ls_pkg::word_t                        rdata;
    ls_pkg::wb_t                          wb_load;
    ls_pkg::wb_t                          wb_ptr;

    ls_reg_file u_reg_file
    (
        .clk     (clk),
        .rst     (rst),
        .host_wb (host_wb),
        .wb_load (wb_load),
        .wb_ptr  (wb_ptr),
        .rd_idx  (rd_idx),
        .rd_data (rd_data),
        .regs    (regs)
    );

    ls_unit u_unit
    (
        .clk       (clk),
        .rst       (rst),
        .regs      (regs),
        .dir_en    (dir_en),
        .dir_store (dir_store),
        .dir_reg   (dir_reg),
        .dir_addr  (dir_addr),
        .op_en     (op_en),
        .op        (op),
        .dbus      (dbus),
        .rdata     (rdata),
        .rcn_req   (rcn_req),
        .wb_load   (wb_load),
        .wb_ptr    (wb_ptr)
    );

    ls_data_ram u_data_ram
    (
        .clk   (clk),
        .dbus  (dbus),
        .rdata (rdata)
    );

endmodule

// File: src/ls_unit.sv
/* Direct requests win over ops; no back-pressure on either bus
   Results retire three edges after issue without forwarding */
`timescale 1ns/10ps

module ls_unit
(
    input  logic                                  clk,
    input  logic                                  rst,

    input  ls_pkg::word_t [ls_pkg::NUM_REGS-1:0]  regs,

    input  logic                                  dir_en,
    input  logic                                  dir_store,
    input  ls_pkg::reg_idx_t                      dir_reg,
    input  ls_pkg::word_t                         dir_addr,

    input  logic                                  op_en,
    input  ls_pkg::ls_op_t                        op,

    output ls_pkg::dbus_req_t                     dbus,
    input  ls_pkg::word_t                         rdata,

    output ls_pkg::rcn_req_t                      rcn_req,

    output ls_pkg::wb_t                           wb_load,
    output ls_pkg::wb_t                           wb_ptr
);

    //////////////////////////////////////////////////
    // Issue, address generation
    //////////////////////////////////////////////////

    ls_pkg::word_t      ptr_word;
    ls_pkg::word_t      data_word;
    ls_pkg::word_t      aligned;
    ls_pkg::word_t      scaled;
    ls_pkg::word_t      addr_sum;
    ls_pkg::word_t      bus_addr;
    ls_pkg::word_t      wdata;
    ls_pkg::byte_mask_t wmask;
    ls_pkg::reg_idx_t   wbreg;
    logic               wren;
    logic               xchg;
    logic               issue;
    logic               local_en;
    logic               remote_en;
    logic               ptr_upd;

    assign ptr_word  = regs[op.ptr];
    assign data_word = dir_en ? regs[dir_reg] : regs[op.data_reg];

    always_comb
    begin
        case (op.size)
            ls_pkg::SIZE_BYTE:
            begin
                aligned = ptr_word;
                scaled  = {27'd0, op.offset};
            end
            ls_pkg::SIZE_HALF:
            begin
                aligned = {ptr_word[31:1], 1'b0};
                scaled  = {26'd0, op.offset, 1'b0};
            end
            default:
            begin
                aligned = {ptr_word[31:2], 2'b00};
                scaled  = {25'd0, op.offset, 2'b00};
            end
        endcase
    end

    assign addr_sum = aligned + scaled;
    assign bus_addr = dir_en ? dir_addr : (op.post_inc ? aligned : addr_sum);

    assign wren  = dir_en ? dir_store : op.store;
    assign xchg  = !dir_en && op.store && (op.size == ls_pkg::SIZE_XCHG);
    assign wbreg = dir_en ? dir_reg : op.data_reg;

    assign issue     = dir_en || op_en;
    assign local_en  = issue && !bus_addr[ls_pkg::RCN_SELECT_BIT];
    assign remote_en = issue && bus_addr[ls_pkg::RCN_SELECT_BIT];
    assign ptr_upd   = !dir_en && op_en && op.post_inc;   // Remote ops update too

    //////////////////////////////////////////////////
    // Store data and byte mask
    //////////////////////////////////////////////////

    always_comb
    begin
        if (dir_en)
        begin
            wdata = data_word;
            wmask = 4'b1111;
        end
        else
        begin
            case (op.size)
                ls_pkg::SIZE_BYTE:
                begin
                    wdata = {4{data_word[7:0]}};
                    wmask = 4'b0001 << bus_addr[1:0];
                end
                ls_pkg::SIZE_HALF:
                begin
                    wdata = {2{data_word[15:0]}};
                    wmask = bus_addr[1] ? 4'b1100 : 4'b0011;
                end
                default:
                begin
                    wdata = data_word;
                    wmask = 4'b1111;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Bus issue
    //////////////////////////////////////////////////

    logic              dbus_cs;
    logic              rcn_cs;
    ls_pkg::dbus_req_t dbus_q;
    ls_pkg::rcn_req_t  rcn_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dbus_cs <= 1'b0;
            rcn_cs  <= 1'b0;
        end
        else
        begin
            dbus_cs <= local_en;
            rcn_cs  <= remote_en;
        end
    end

    always_ff @(posedge clk)
    begin
        if (local_en)
        begin
            dbus_q <= '{cs: 1'b1, wr: wren, addr: bus_addr, mask: wmask, wdata: wdata};
        end
        if (remote_en)
        begin
            rcn_q <= '{cs: 1'b1, xch: xchg, wr: wren, addr: bus_addr, wbreg: wbreg,
                       mask: wmask, wdata: wdata};
        end
    end

    assign dbus = '{cs: dbus_cs, wr: dbus_q.wr, addr: dbus_q.addr, mask: dbus_q.mask,
                    wdata: dbus_q.wdata};

    assign rcn_req = '{cs: rcn_cs, xch: rcn_q.xch, wr: rcn_q.wr, addr: rcn_q.addr,
                       wbreg: rcn_q.wbreg, mask: rcn_q.mask, wdata: rcn_q.wdata};

    //////////////////////////////////////////////////
    // Retire pipeline
    //////////////////////////////////////////////////

    logic [2:0]         ld_q;          // Bit 2 is the last stage
    logic [2:0]         ptr_en_q;
    ls_pkg::reg_idx_t   wbreg_q [3];
    ls_pkg::byte_mask_t mask_q [3];
    ls_pkg::reg_idx_t   ptr_idx_q [3];
    ls_pkg::word_t      ptr_data_q [3];
    ls_pkg::word_t      rdata_q;
    ls_pkg::word_t      load_data;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ld_q     <= '0;
            ptr_en_q <= '0;
        end
        else
        begin
            ld_q     <= {ld_q[1:0], local_en && (!wren || xchg)};
            ptr_en_q <= {ptr_en_q[1:0], ptr_upd};
        end
    end

    always_ff @(posedge clk)
    begin
        wbreg_q[0]    <= wbreg;
        mask_q[0]     <= wmask;
        ptr_idx_q[0]  <= op.ptr;
        ptr_data_q[0] <= addr_sum;
        for (int s = 1; s < 3; s++)
        begin
            wbreg_q[s]    <= wbreg_q[s-1];
            mask_q[s]     <= mask_q[s-1];
            ptr_idx_q[s]  <= ptr_idx_q[s-1];
            ptr_data_q[s] <= ptr_data_q[s-1];
        end
        rdata_q <= rdata;   // RAM word, valid here two edges after issue
    end

    // Lane select and zero extension by the delayed mask
    always_comb
    begin
        case (mask_q[2])
            4'b1111: load_data = rdata_q;
            4'b0011: load_data = {16'd0, rdata_q[15:0]};
            4'b1100: load_data = {16'd0, rdata_q[31:16]};
            4'b0010: load_data = {24'd0, rdata_q[15:8]};
            4'b0100: load_data = {24'd0, rdata_q[23:16]};
            4'b1000: load_data = {24'd0, rdata_q[31:24]};
            default: load_data = {24'd0, rdata_q[7:0]};
        endcase
    end

    assign wb_load = '{en: ld_q[2], idx: wbreg_q[2], data: load_data};
    assign wb_ptr  = '{en: ptr_en_q[2], idx: ptr_idx_q[2], data: ptr_data_q[2]};

endmodule

// File: tests/ls_checker.sv
/* Bus select and load retire timing of ls_unit
   Bound to the unit and fed from its request ports and bus outputs */
`timescale 1ns/10ps

module ls_checker
(
    input logic              clk,
    input logic              rst,
    input logic              dir_en,
    input logic              dir_store,
    input logic              op_en,
    input ls_pkg::ls_op_t    op,
    input ls_pkg::dbus_req_t dbus,
    input ls_pkg::rcn_req_t  rcn_req,
    input ls_pkg::wb_t       wb_load
);

    logic issue;
    logic load_issue;

    assign issue      = dir_en || op_en;
    assign load_issue = issue && (dir_en ? !dir_store
                                         : (!op.store || (op.size == ls_pkg::SIZE_XCHG)));
                                         // Exchanges return data too

    //////////////////////////////////////////////////
    // Chip selects
    //////////////////////////////////////////////////

    a_one_bus: assert property (@(posedge clk) disable iff (rst)
        !(dbus.cs && rcn_req.cs))
        else $error("Local and remote chip selects are high in the same cycle");

    a_cs_issue: assert property (@(posedge clk) disable iff (rst)
        (dbus.cs || rcn_req.cs) == $past(issue))
        else $error("A chip select does not follow an issue by exactly one cycle");

    a_dbus_local: assert property (@(posedge clk) disable iff (rst)
        dbus.cs |-> !dbus.addr[ls_pkg::RCN_SELECT_BIT])
        else $error("Local chip select is high for a remote address");

    a_rcn_remote: assert property (@(posedge clk) disable iff (rst)
        rcn_req.cs |-> rcn_req.addr[ls_pkg::RCN_SELECT_BIT])
        else $error("Remote chip select is high for a local address");

    //////////////////////////////////////////////////
    // Load retire
    //////////////////////////////////////////////////

    a_load_wb: assert property (@(posedge clk) disable iff (rst)
        wb_load.en == ($past(dbus.cs, 2) && $past(load_issue, 3)))
        else $error("Load write back is not three cycles after its local issue");

endmodule

// File: tests/ls_tb.sv
/* Issues one request at a time and checks registers against a reference model
   Local addresses stay below 4 KB, so the data RAM never aliases */
`timescale 1ns/10ps

module ls_tb;

    logic               clk;
    logic               rst;
    ls_pkg::wb_t        host_wb;
    ls_pkg::reg_idx_t   rd_idx;
    ls_pkg::word_t      rd_data;
    logic               dir_en;
    logic               dir_store;
    ls_pkg::reg_idx_t   dir_reg;
    ls_pkg::word_t      dir_addr;
    logic               op_en;
    ls_pkg::ls_op_t     op;
    ls_pkg::rcn_req_t   rcn_req;

    ls_pkg::word_t      ref_regs [ls_pkg::NUM_REGS];
    ls_pkg::word_t      ref_mem [ls_pkg::word_t];   // Keyed by word address
    int                 seed;

    ls_top u_ls_top
    (
        .clk       (clk),
        .rst       (rst),
        .host_wb   (host_wb),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data),
        .dir_en    (dir_en),
        .dir_store (dir_store),
        .dir_reg   (dir_reg),
        .dir_addr  (dir_addr),
        .op_en     (op_en),
        .op        (op),
        .rcn_req   (rcn_req)
    );

    bind ls_unit ls_checker u_checker
    (
        .clk       (clk),
        .rst       (rst),
        .dir_en    (dir_en),
        .dir_store (dir_store),
        .op_en     (op_en),
        .op        (op),
        .dbus      (dbus),
        .rcn_req   (rcn_req),
        .wb_load   (wb_load)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic int unsigned lane_bytes(input ls_pkg::size_t size);
        case (size)
            ls_pkg::SIZE_BYTE: return 1;
            ls_pkg::SIZE_HALF: return 2;
            default:           return 4;
        endcase
    endfunction

    function automatic ls_pkg::word_t read_mem(input ls_pkg::word_t addr);
        if (ref_mem.exists(addr >> 2))
            return ref_mem[addr >> 2];
        return '0;
    endfunction

    // Bus address, byte lanes and pointer write back value of one op
    function automatic void ref_access(input ls_pkg::ls_op_t o, input ls_pkg::word_t ptr_val,
                                       output ls_pkg::word_t addr,
                                       output ls_pkg::byte_mask_t mask,
                                       output ls_pkg::word_t ptr_new);
        int unsigned   n;
        ls_pkg::word_t base;
        n       = lane_bytes(o.size);
        base    = ptr_val & ~(n - 1);
        ptr_new = base + o.offset * n;
        addr    = o.post_inc ? base : ptr_new;
        mask    = '0;
        for (int b = 0; b < 4; b++)
            mask[b] = (b / n) == (addr[1:0] / n);
    endfunction

    function automatic ls_pkg::word_t ref_wdata(input ls_pkg::word_t data,
                                                input ls_pkg::size_t size);
        ls_pkg::word_t wd;
        int unsigned   n;
        n = lane_bytes(size);
        for (int b = 0; b < 4; b++)
            wd[8*b +: 8] = data[8*(b % n) +: 8];
        return wd;
    endfunction

    function automatic ls_pkg::word_t ref_load(input ls_pkg::word_t mem_word,
                                               input ls_pkg::word_t addr,
                                               input ls_pkg::size_t size);
        ls_pkg::word_t lane;
        lane = mem_word >> (8 * addr[1:0]);
        case (size)
            ls_pkg::SIZE_BYTE: return lane & 32'h0000_00ff;
            ls_pkg::SIZE_HALF: return lane & 32'h0000_ffff;
            default:           return mem_word;
        endcase
    endfunction

    function automatic ls_pkg::ls_op_t make_op(input logic store, input logic post_inc,
                                               input ls_pkg::size_t size, input int offset,
                                               input ls_pkg::reg_idx_t ptr,
                                               input ls_pkg::reg_idx_t data_reg);
        return '{store: store, post_inc: post_inc, size: size,
                 offset: ls_pkg::offset_t'(offset), ptr: ptr, data_reg: data_reg};
    endfunction

    //////////////////////////////////////////////////
    // Drive and compare
    //////////////////////////////////////////////////

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic write_reg(input ls_pkg::reg_idx_t idx, input ls_pkg::word_t data);
        host_wb = '{en: 1'b1, idx: idx, data: data};
        @(posedge clk);
        #1;
        host_wb.en    = 1'b0;
        ref_regs[idx] = data;
    endtask

    task automatic check_reg(input ls_pkg::reg_idx_t idx, input string what);
        rd_idx = idx;
        #1;
        assert (rd_data == ref_regs[idx])
        else
        begin
            $display("Fail at %0t ns: %s, r%0d is %h, expected %h",
                     $time, what, idx, rd_data, ref_regs[idx]);
            stop_run();
        end
        @(posedge clk);
        #1;
    endtask

    // Starts right after the issue edge, ends after the register file write
    task automatic wait_retire();
        int edges;
        edges = 0;
        while (!(u_ls_top.wb_load.en || u_ls_top.wb_ptr.en))
        begin
            if (edges > 8)
            begin
                $display("Timeout at %0t ns: the unit never wrote a register back", $time);
                stop_run();
            end
            @(posedge clk);
            #1;
            edges++;
        end
        @(posedge clk);
        #1;
        edges++;
        assert (edges == 3)
        else
        begin
            $display("Fail at %0t ns: register visible %0d edges after issue, expected 3",
                     $time, edges);
            stop_run();
        end
    endtask

    task automatic check_remote(input ls_pkg::ls_op_t o, input ls_pkg::word_t addr,
                                input ls_pkg::byte_mask_t mask, input ls_pkg::word_t wd);
        ls_pkg::rcn_req_t exp;
        ls_pkg::rcn_req_t seen;
        exp  = '{cs: 1'b1, xch: o.store && (o.size == ls_pkg::SIZE_XCHG), wr: o.store,
                 addr: addr, wbreg: o.data_reg, mask: mask, wdata: wd};
        seen = rcn_req;
        if (!o.store)
            seen.wdata = exp.wdata;   // Store data means nothing on a load
        assert (seen == exp && !u_ls_top.dbus.cs)
        else
        begin
            $display("Fail at %0t ns: remote request %h with local cs %b, expected %h",
                     $time, rcn_req, u_ls_top.dbus.cs, exp);
            stop_run();
        end
    endtask

    task automatic run_direct(input logic store, input ls_pkg::reg_idx_t r,
                              input ls_pkg::word_t addr);
        ls_pkg::word_t old_word;
        old_word  = read_mem(addr);
        dir_en    = 1'b1;
        dir_store = store;
        dir_reg   = r;
        dir_addr  = addr;
        @(posedge clk);
        #1;
        dir_en = 1'b0;
        if (store)
        begin
            ref_mem[addr >> 2] = ref_regs[r];
            idle_cycles(2);
        end
        else
        begin
            ref_regs[r] = old_word;
            wait_retire();
        end
        check_reg(r, "direct access");
    endtask

    task automatic run_op(input ls_pkg::ls_op_t o);
        ls_pkg::word_t      addr;
        ls_pkg::byte_mask_t mask;
        ls_pkg::word_t      ptr_new;
        ls_pkg::word_t      old_word;
        ls_pkg::word_t      wd;
        ls_pkg::word_t      merged;
        logic               remote;
        logic               loads;
        ref_access(o, ref_regs[o.ptr], addr, mask, ptr_new);
        remote   = addr[ls_pkg::RCN_SELECT_BIT];
        loads    = !remote && (!o.store || o.size == ls_pkg::SIZE_XCHG);
        old_word = read_mem(addr);
        wd       = ref_wdata(ref_regs[o.data_reg], o.size);
        merged   = old_word;
        for (int b = 0; b < 4; b++)
            if (mask[b])
                merged[8*b +: 8] = wd[8*b +: 8];
        op    = o;
        op_en = 1'b1;
        @(posedge clk);
        #1;
        op_en = 1'b0;
        if (remote)
            check_remote(o, addr, mask, wd);
        else if (o.store)
            ref_mem[addr >> 2] = merged;
        if (loads)
            ref_regs[o.data_reg] = ref_load(old_word, addr, o.size);
        if (o.post_inc)
            ref_regs[o.ptr] = ptr_new;
        if (loads || o.post_inc)
            wait_retire();
        else
            idle_cycles(4);
        check_reg(o.data_reg, "op data register");
        check_reg(o.ptr, "op pointer register");
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial
    begin
        ls_pkg::word_t      addr;
        ls_pkg::byte_mask_t mask;
        ls_pkg::word_t      ptr_new;
        ls_pkg::ls_op_t     o;
        seed      = 74;
        rst       = 1'b1;
        host_wb   = '0;
        rd_idx    = '0;
        dir_en    = 1'b0;
        dir_store = 1'b0;
        dir_reg   = '0;
        dir_addr  = '0;
        op_en     = 1'b0;
        op        = '0;
        for (int i = 0; i < ls_pkg::NUM_REGS; i++)
            ref_regs[i] = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // Direct word store and load
        write_reg(3'd1, 32'hcafe_0123);
        run_direct(1'b1, 3'd1, 32'h0000_0100);
        run_direct(1'b0, 3'd2, 32'h0000_0100);

        // Every byte lane at 0x200 and both halves at 0x204
        write_reg(3'd3, 32'h0000_0200);
        for (int lane = 0; lane < 4; lane++)
        begin
            write_reg(3'd4, $random(seed));
            run_op(make_op(1'b1, 1'b0, ls_pkg::SIZE_BYTE, lane, 3'd3, 3'd4));
        end
        for (int half = 2; half < 4; half++)
        begin
            write_reg(3'd4, $random(seed));
            run_op(make_op(1'b1, 1'b0, ls_pkg::SIZE_HALF, half, 3'd3, 3'd4));
        end
        run_op(make_op(1'b0, 1'b0, ls_pkg::SIZE_WORD, 0, 3'd3, 3'd5));
        run_op(make_op(1'b0, 1'b0, ls_pkg::SIZE_WORD, 1, 3'd3, 3'd5));
        for (int lane = 0; lane < 4; lane++)
            run_op(make_op(1'b0, 1'b0, ls_pkg::SIZE_BYTE, lane, 3'd3, 3'd5));
        for (int half = 2; half < 4; half++)
            run_op(make_op(1'b0, 1'b0, ls_pkg::SIZE_HALF, half, 3'd3, 3'd5));

        // Random pre-index ops, then random post-increment ops
        for (int mode = 0; mode < 2; mode++)
        begin
            for (int i = 0; i < 8; i++)
            begin
                write_reg(3'd3, $random(seed) & 32'h0000_0eff);
                write_reg(3'd4, $random(seed));
                o = make_op(1'($random(seed)), 1'(mode),
                            ls_pkg::size_t'($unsigned($random(seed)) % 3),
                            $random(seed), 3'd3, 3'd4);
                ref_access(o, ref_regs[3], addr, mask, ptr_new);
                write_reg(3'd6, $random(seed));
                run_direct(1'b1, 3'd6, addr & ~32'h3);   // Known word under the access
                run_op(o);
                run_direct(1'b0, 3'd6, addr & ~32'h3);   // Word where the access landed
            end
        end

        // Exchange returns the old word and leaves the new one
        write_reg(3'd3, 32'h0000_0300);
        write_reg(3'd4, 32'h1111_2222);
        run_op(make_op(1'b1, 1'b0, ls_pkg::SIZE_WORD, 0, 3'd3, 3'd4));
        write_reg(3'd4, 32'h3333_4444);
        run_op(make_op(1'b1, 1'b0, ls_pkg::SIZE_XCHG, 0, 3'd3, 3'd4));
        run_op(make_op(1'b0, 1'b0, ls_pkg::SIZE_XCHG, 0, 3'd3, 3'd5));

        // Remote store with pointer update, then a remote load
        write_reg(3'd3, 32'h8000_0041);
        write_reg(3'd4, $random(seed));
        run_op(make_op(1'b1, 1'b1, ls_pkg::SIZE_HALF, 3, 3'd3, 3'd4));
        run_op(make_op(1'b0, 1'b0, ls_pkg::SIZE_BYTE, 5, 3'd3, 3'd4));

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
